// ==== Makefile ====
# Verilator build for the Cholesky factorizer testbench

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_cholesky
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
RUN_FLAGS  ?= +verilator+error+limit+1000
PASS_MSG   := Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/chol_macros.svh ====
`ifndef CHOL_MACROS_SVH
`define CHOL_MACROS_SVH

// Matrix geometry
`define CHOL_N          5
`define CHOL_ELEMS      15      // Lower triangle words, N*(N+1)/2

// Fixed-point format
`define CHOL_WORD_BITS  32      // Q16.16 word
`define CHOL_FRAC_BITS  16
`define CHOL_ACC_BITS   64      // Product sum, window 47:16 is used

// Worst case from accept to out_valid.
// Per-element overhead, one cycle per product term, 24 root iterations
// plus load and finish per diagonal, 32 divide iterations plus load and
// finish per off-diagonal element, then some slack.
`define CHOL_MAX_CYCLES (`CHOL_ELEMS * 4 \
    + (`CHOL_N - 1) * `CHOL_N * (`CHOL_N + 1) / 6 \
    + `CHOL_N * 26 \
    + (`CHOL_ELEMS - `CHOL_N) * 34 \
    + 64)

`endif

// ==== source/chol_div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_macros.svh"

module chol_div_unit (
    input  logic              clk,
    input  logic              rst,
    input  chol_pkg::op_req_t req,
    input  logic              req_valid,
    output chol_pkg::fixed_t  res,
    output logic              res_valid
);

    localparam int Q_BITS   = `CHOL_WORD_BITS;     // One quotient bit per iteration
    localparam int REM_BITS = Q_BITS + 2;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIN} state_t;

    state_t              state;
    logic [4:0]          cnt;
    logic                neg;                       // Quotient sign
    logic [Q_BITS-1:0]   op_mag;
    logic [Q_BITS-1:0]   dvs_mag;
    logic [Q_BITS-1:0]   dvd;                       // Low dividend bits still to bring down
    logic [Q_BITS-1:0]   dvs;
    logic [Q_BITS-1:0]   quo;
    logic [REM_BITS-1:0] rem;
    logic [REM_BITS-1:0] rem_sh;
    logic                fits;

    always_comb begin
        op_mag  = req.operand[Q_BITS-1] ? Q_BITS'(-req.operand) : req.operand;
        dvs_mag = req.divisor[Q_BITS-1] ? Q_BITS'(-req.divisor) : req.divisor;
        rem_sh  = {rem[REM_BITS-2:0], dvd[Q_BITS-1]};
        fits    = (rem_sh >= {2'b00, dvs});
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        cnt   <= '0;
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(Q_BITS - 1)) begin
                        state <= S_FIN;
                    end
                end
                S_FIN: begin
                    res_valid <= 1'b1;
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            // Dividend is |operand| << 16, upper 16 bits go straight in
            rem <= REM_BITS'(op_mag[Q_BITS-1:`CHOL_FRAC_BITS]);
            dvd <= {op_mag[`CHOL_FRAC_BITS-1:0], {(Q_BITS - `CHOL_FRAC_BITS){1'b0}}};
            dvs <= dvs_mag;
            quo <= '0;
            neg <= (req.operand[Q_BITS-1] ^ req.divisor[Q_BITS-1]) && (req.divisor != '0);
        end else if (state == S_RUN) begin
            rem <= fits ? rem_sh - {2'b00, dvs} : rem_sh;
            dvd <= dvd << 1;
            quo <= {quo[Q_BITS-2:0], fits};
        end
        if (state == S_FIN) begin
            res <= neg ? -quo : quo;    // Zero divisor leaves all ones
        end
    end

endmodule

`default_nettype wire

// ==== source/chol_matrix_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module chol_matrix_loader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  chol_pkg::tri_matrix_t a_in,
    output logic                  in_ready,
    input  chol_pkg::elem_idx_t   rd_idx,
    output chol_pkg::fixed_t      a_elem,
    output logic                  start,
    input  logic                  done
);

    import chol_pkg::*;

    tri_matrix_t a_q;       // Held copy of A
    logic        busy;
    logic        done_q;
    logic        accept;

    assign accept   = in_valid && !busy;
    assign in_ready = !busy;
    assign a_elem   = a_q[rd_idx];      // Sequencer reads one word at a time

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            start  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            start  <= accept;           // One-cycle pulse after the accept edge
            done_q <= done;             // Lets out_valid go out before in_ready rises
            if (accept) begin
                busy <= 1'b1;
            end else if (done_q) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a_in;
        end
    end

endmodule

`default_nettype wire

// ==== source/chol_pkg.sv ====
`default_nettype none

`include "chol_macros.svh"

package chol_pkg;

    // ==================================================
    // Scalar types
    // ==================================================

    typedef logic signed [`CHOL_WORD_BITS-1:0] fixed_t;    // Signed Q16.16

    typedef logic [3:0] elem_idx_t;                         // Triangle position 0..14

    typedef logic signed [`CHOL_ACC_BITS-1:0] acc_t;

    // Element 0 is (1,1), then (2,1), (2,2), (3,1) and so on row by row
    typedef fixed_t [`CHOL_ELEMS-1:0] tri_matrix_t;

    // ==================================================
    // Transfer records
    // ==================================================

    // Request to the square-root or divide unit
    typedef struct packed {
        fixed_t    operand;     // Radicand or dividend
        fixed_t    divisor;     // L(j,j), root unit ignores it
        elem_idx_t idx;         // Destination element
    } op_req_t;

    // One finished element of L
    typedef struct packed {
        elem_idx_t idx;
        fixed_t    value;
        logic      last;        // Set on element (5,5)
    } l_write_t;

endpackage

`default_nettype wire

// ==== source/chol_result_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module chol_result_collector (
    input  logic                  clk,
    input  logic                  rst,
    input  chol_pkg::l_write_t    wr,
    input  logic                  wr_valid,
    output chol_pkg::tri_matrix_t l_out,
    output logic                  out_valid
);

    import chol_pkg::*;

    tri_matrix_t stage;         // Elements of the factor in progress
    tri_matrix_t stage_next;
    logic        finish;

    assign finish = wr_valid && wr.last;

    always_comb begin
        stage_next = stage;
        if (wr_valid) begin
            stage_next[wr.idx] = wr.value;
        end
    end

    always_ff @(posedge clk) begin
        stage <= stage_next;
    end

    // ==================================================
    // Published result
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            l_out     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= finish;        // Single-cycle pulse
            if (finish) begin
                l_out <= stage_next;    // Whole factor changes at once
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/chol_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_macros.svh"

module chol_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output chol_pkg::elem_idx_t  rd_idx,
    input  chol_pkg::fixed_t     a_elem,
    output chol_pkg::op_req_t    sqrt_req,
    output logic                 sqrt_req_valid,
    input  chol_pkg::fixed_t     sqrt_res,
    input  logic                 sqrt_res_valid,
    output chol_pkg::op_req_t    div_req,
    output logic                 div_req_valid,
    input  chol_pkg::fixed_t     div_res,
    input  logic                 div_res_valid,
    output chol_pkg::l_write_t   wr,
    output logic                 wr_valid,
    output logic                 done
);

    import chol_pkg::*;

    localparam logic [2:0] LAST_POS = 3'(`CHOL_N - 1);

    typedef enum logic [1:0] {S_IDLE, S_ACC, S_WAIT} state_t;

    function automatic elem_idx_t tri_idx(input logic [2:0] r, input logic [2:0] c);
        int flat;
        flat = (int'(r) * (int'(r) + 1)) / 2 + int'(c);
        return elem_idx_t'(flat);
    endfunction

    state_t    state;
    logic [2:0] col;                    // j, current column
    logic [2:0] row;                    // i, row at or below the diagonal
    logic [2:0] k;                      // Product term index, runs below col
    acc_t      acc;
    acc_t      prod;
    fixed_t    diff;
    fixed_t    res_val;
    fixed_t    l_mem [`CHOL_ELEMS];     // L values computed so far
    op_req_t   req_q;
    elem_idx_t idx_rc;
    elem_idx_t idx_rk;
    elem_idx_t idx_ck;
    elem_idx_t idx_cc;
    logic      on_diag;
    logic      res_hit;
    logic      last_elem;

    // ==================================================
    // Addressing and datapath
    // ==================================================

    assign idx_rc    = tri_idx(row, col);
    assign idx_rk    = tri_idx(row, k);
    assign idx_ck    = tri_idx(col, k);
    assign idx_cc    = tri_idx(col, col);
    assign rd_idx    = idx_rc;
    assign on_diag   = (row == col);
    assign last_elem = (row == LAST_POS) && (col == LAST_POS);

    assign prod    = acc_t'(l_mem[idx_rk]) * acc_t'(l_mem[idx_ck]);   // L(i,k)*L(j,k)
    assign diff    = a_elem - fixed_t'(acc[`CHOL_FRAC_BITS +: `CHOL_WORD_BITS]);
    assign res_hit = on_diag ? sqrt_res_valid : div_res_valid;
    assign res_val = on_diag ? sqrt_res : div_res;

    assign sqrt_req = req_q;            // Both units see the same held request
    assign div_req  = req_q;

    // ==================================================
    // Column and row walk
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= S_IDLE;
            col            <= '0;
            row            <= '0;
            k              <= '0;
            acc            <= '0;
            sqrt_req_valid <= 1'b0;
            div_req_valid  <= 1'b0;
            wr_valid       <= 1'b0;
            done           <= 1'b0;
        end else begin
            sqrt_req_valid <= 1'b0;
            div_req_valid  <= 1'b0;
            wr_valid       <= 1'b0;
            done           <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        col   <= '0;
                        row   <= '0;
                        k     <= '0;
                        acc   <= '0;
                        state <= S_ACC;
                    end
                end
                S_ACC: begin
                    if (k != col) begin
                        acc <= acc + prod;          // One product per cycle
                        k   <= k + 3'd1;
                    end else begin
                        sqrt_req_valid <= on_diag;
                        div_req_valid  <= !on_diag;
                        state          <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (res_hit) begin
                        wr_valid <= 1'b1;
                        done     <= last_elem;
                        k        <= '0;
                        acc      <= '0;
                        state    <= last_elem ? S_IDLE : S_ACC;
                        if (row == LAST_POS) begin
                            col <= col + 3'd1;      // Next column starts on its diagonal
                            row <= col + 3'd1;
                        end else begin
                            row <= row + 3'd1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_ACC && k == col) begin
            req_q.operand <= diff;                  // A(i,j) minus the product sum
            req_q.divisor <= on_diag ? '0 : l_mem[idx_cc];
            req_q.idx     <= idx_rc;
        end
        if (state == S_WAIT && res_hit) begin
            l_mem[req_q.idx] <= res_val;
            wr.idx           <= req_q.idx;
            wr.value         <= res_val;
            wr.last          <= last_elem;
        end
    end

endmodule

`default_nettype wire

// ==== source/chol_sqrt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_macros.svh"

module chol_sqrt_unit (
    input  logic              clk,
    input  logic              rst,
    input  chol_pkg::op_req_t req,
    input  logic              req_valid,
    output chol_pkg::fixed_t  res,
    output logic              res_valid
);

    localparam int RAD_BITS  = `CHOL_WORD_BITS + `CHOL_FRAC_BITS;    // Operand shifted up
    localparam int ROOT_BITS = RAD_BITS / 2;                          // One bit per iteration
    localparam int REM_BITS  = ROOT_BITS + 4;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIN} state_t;

    state_t               state;
    logic [4:0]           cnt;
    logic [RAD_BITS-1:0]  rad;
    logic [ROOT_BITS-1:0] root;
    logic [REM_BITS-1:0]  rem;
    logic [REM_BITS-1:0]  rem_sh;
    logic [REM_BITS-1:0]  trial;
    logic                 fits;

    // Bring down two radicand bits, try 4*root+1
    always_comb begin
        rem_sh = {rem[REM_BITS-3:0], rad[RAD_BITS-1 -: 2]};
        trial  = REM_BITS'({root, 2'b01});
        fits   = (rem_sh >= trial);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        cnt   <= '0;
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(ROOT_BITS - 1)) begin
                        state <= S_FIN;
                    end
                end
                S_FIN: begin
                    res_valid <= 1'b1;
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            rad  <= {req.operand, {`CHOL_FRAC_BITS{1'b0}}};
            root <= '0;
            rem  <= '0;
        end else if (state == S_RUN) begin
            rad  <= rad << 2;
            rem  <= fits ? rem_sh - trial : rem_sh;
            root <= {root[ROOT_BITS-2:0], fits};
        end
        if (state == S_FIN) begin
            res <= {{(`CHOL_WORD_BITS - ROOT_BITS){1'b0}}, root};   // Root is never negative
        end
    end

endmodule

`default_nettype wire

// ==== source/cholesky_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cholesky_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  chol_pkg::tri_matrix_t a_in,
    output logic                  in_ready,
    output chol_pkg::tri_matrix_t l_out,
    output logic                  out_valid
);

    import chol_pkg::*;

    elem_idx_t rd_idx;
    fixed_t    a_elem;
    logic      start;
    logic      done;
    op_req_t   sqrt_req;
    op_req_t   div_req;
    logic      sqrt_req_valid;
    logic      div_req_valid;
    fixed_t    sqrt_res;
    fixed_t    div_res;
    logic      sqrt_res_valid;
    logic      div_res_valid;
    l_write_t  wr;
    logic      wr_valid;

    // ==================================================
    // Input side
    // ==================================================

    chol_matrix_loader loader0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a_in     (a_in),
        .in_ready (in_ready),
        .rd_idx   (rd_idx),
        .a_elem   (a_elem),
        .start    (start),
        .done     (done)
    );

    // ==================================================
    // Processing
    // ==================================================

    chol_sequencer seq0 (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .rd_idx         (rd_idx),
        .a_elem         (a_elem),
        .sqrt_req       (sqrt_req),
        .sqrt_req_valid (sqrt_req_valid),
        .sqrt_res       (sqrt_res),
        .sqrt_res_valid (sqrt_res_valid),
        .div_req        (div_req),
        .div_req_valid  (div_req_valid),
        .div_res        (div_res),
        .div_res_valid  (div_res_valid),
        .wr             (wr),
        .wr_valid       (wr_valid),
        .done           (done)
    );

    chol_sqrt_unit sqrt0 (
        .clk       (clk),
        .rst       (rst),
        .req       (sqrt_req),
        .req_valid (sqrt_req_valid),
        .res       (sqrt_res),
        .res_valid (sqrt_res_valid)
    );

    chol_div_unit div0 (
        .clk       (clk),
        .rst       (rst),
        .req       (div_req),
        .req_valid (div_req_valid),
        .res       (div_res),
        .res_valid (div_res_valid)
    );

    // ==================================================
    // Output side
    // ==================================================

    chol_result_collector collect0 (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .l_out     (l_out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
source/chol_pkg.sv
source/chol_matrix_loader.sv
source/chol_sequencer.sv
source/chol_sqrt_unit.sv
source/chol_div_unit.sv
source/chol_result_collector.sv
source/cholesky_top.sv
tb/chol_clock_gen.sv
tb/chol_properties.sv
tb/tb_cholesky.sv

// ==== tb/chol_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module chol_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a falling edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/chol_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_macros.svh"

module chol_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_valid,
    input logic                  in_ready,
    input chol_pkg::tri_matrix_t l_out,
    input logic                  out_valid
);

    logic        pending;               // Matrix accepted, factor not out yet
    int unsigned wait_cycles;
    int unsigned fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending     <= 1'b0;
            wait_cycles <= '0;
        end else if (in_valid && in_ready) begin
            pending     <= 1'b1;
            wait_cycles <= '0;
        end else if (out_valid) begin
            pending <= 1'b0;
        end else if (pending) begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    // ==================================================
    // Handshake rules
    // ==================================================

    assert property (@(posedge clk) disable iff (rst) pending |-> !in_ready)
        else begin
            $error("in_ready high while a matrix is in flight");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) pending |-> wait_cycles <= `CHOL_MAX_CYCLES)
        else begin
            $error("result later than the worst-case cycle bound");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) out_valid |-> pending)
        else begin
            $error("out_valid without an accepted matrix");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
        else begin
            $error("out_valid high on two consecutive cycles");
            fail_count++;
        end

    // Factor only changes together with the pulse
    assert property (@(posedge clk) disable iff (rst) !out_valid |-> $stable(l_out))
        else begin
            $error("l_out changed between out_valid pulses");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== tb/tb_cholesky.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_macros.svh"

module tb_cholesky;

    import chol_pkg::*;

    localparam int TEST_RESULTS = 12;                   // Factors the run waits for
    localparam int CYCLE_LIMIT  = (TEST_RESULTS + 2) * `CHOL_MAX_CYCLES;
    localparam int ONE          = 1 << `CHOL_FRAC_BITS;

    logic        clk;
    logic        rst;
    logic        in_valid;
    tri_matrix_t a_in;
    logic        in_ready;
    tri_matrix_t l_out;
    logic        out_valid;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;
    int cycle_count = 0;
    int pulse_count = 0;
    int l_fac [`CHOL_N][`CHOL_N];       // Integer factor of the current test

    chol_clock_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    cholesky_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a_in      (a_in),
        .in_ready  (in_ready),
        .l_out     (l_out),
        .out_valid (out_valid)
    );

    bind cholesky_top chol_properties props0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .l_out     (l_out),
        .out_valid (out_valid)
    );

    // ==================================================
    // Reference model
    // ==================================================

    function automatic int tri_pos(input int r, input int c);
        return r * (r + 1) / 2 + c;     // Row by row with (1,1) first
    endfunction

    function automatic tri_matrix_t factor_words();
        tri_matrix_t w;
        w = '0;
        for (int r = 0; r < `CHOL_N; r++) begin
            for (int c = 0; c <= r; c++) begin
                w[tri_pos(r, c)] = fixed_t'(l_fac[r][c] * ONE);
            end
        end
        return w;
    endfunction

    // A = L * L^T over the lower triangle
    function automatic tri_matrix_t product_words();
        tri_matrix_t w;
        int          sum;
        w = '0;
        for (int r = 0; r < `CHOL_N; r++) begin
            for (int c = 0; c <= r; c++) begin
                sum = 0;
                for (int k = 0; k <= c; k++) begin
                    sum = sum + l_fac[r][k] * l_fac[c][k];
                end
                w[tri_pos(r, c)] = fixed_t'(sum * ONE);
            end
        end
        return w;
    endfunction

    task automatic pick_random_factor();
        int v;
        for (int r = 0; r < `CHOL_N; r++) begin
            for (int c = 0; c < `CHOL_N; c++) begin
                if (r == c) begin
                    v = $random(seed) % 8;
                    l_fac[r][c] = (v < 0 ? -v : v) + 1;     // Diagonal 1..8
                end else if (c < r) begin
                    l_fac[r][c] = $random(seed) % 9;        // -8..8
                end else begin
                    l_fac[r][c] = 0;
                end
            end
        end
    endtask

    task automatic set_scaled_identity(input int d);
        for (int r = 0; r < `CHOL_N; r++) begin
            for (int c = 0; c < `CHOL_N; c++) begin
                l_fac[r][c] = (r == c) ? d : 0;
            end
        end
    endtask

    // ==================================================
    // Driving and checking
    // ==================================================

    task automatic send_matrix(input tri_matrix_t a);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < `CHOL_MAX_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("in_ready stayed low at %0t, matrix could not be sent", $time);
            errors++;
        end
        a_in     = a;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Returns on the falling edge inside the out_valid pulse
    task automatic wait_for_result(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited <= `CHOL_MAX_CYCLES + 4) begin
            @(negedge clk);
            waited++;
            if (out_valid) seen = 1'b1;
        end
        if (!seen) begin
            $display("no out_valid within %0d cycles, at %0t", waited, $time);
            errors++;
        end
    endtask

    task automatic compare_factor(input tri_matrix_t expected);
        for (int e = 0; e < `CHOL_ELEMS; e++) begin
            assert (l_out[e] == expected[e]) else begin
                $display("mismatch at %0t: element %0d is %h, expected %h",
                         $time, e, l_out[e], expected[e]);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run hung: no finish after %0d cycles, at %0t", cycle_count, $time);
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (out_valid) pulse_count <= pulse_count + 1;
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        tri_matrix_t a_first;
        tri_matrix_t l_first;
        tri_matrix_t a_second;
        tri_matrix_t l_second;
        int          errs_before;
        int          pulses_before;
        bit          seen;

        in_valid     = 1'b0;
        a_in         = '0;
        seed         = 73;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        wait (!rst);
        @(negedge clk);

        errs_before = errors;
        assert (in_ready && !out_valid && l_out == '0) else begin
            $display("mismatch at %0t: state after reset in_ready %b out_valid %b",
                     $time, in_ready, out_valid);
            errors++;
        end
        end_test("reset state", errs_before);

        errs_before = errors;
        set_scaled_identity(3);
        pulses_before = pulse_count;
        send_matrix(product_words());
        wait_for_result(seen);
        if (seen) compare_factor(factor_words());
        repeat (8) @(negedge clk);
        assert (pulse_count - pulses_before == 1) else begin
            $display("mismatch at %0t: %0d out_valid pulses for one matrix",
                     $time, pulse_count - pulses_before);
            errors++;
        end
        end_test("scaled identity", errs_before);

        for (int t = 0; t < 8; t++) begin
            errs_before = errors;
            pick_random_factor();
            send_matrix(product_words());
            wait_for_result(seen);
            if (seen) compare_factor(factor_words());
            end_test($sformatf("random factor %0d", t), errs_before);
        end

        // A matrix offered while busy must leave no trace
        errs_before = errors;
        pick_random_factor();
        a_first = product_words();
        l_first = factor_words();
        send_matrix(a_first);
        repeat (2) @(negedge clk);
        a_second = a_first;
        // Element (5,5) is read long after the offer
        a_second[`CHOL_ELEMS-1] = a_first[`CHOL_ELEMS-1] + fixed_t'(7 * ONE);
        a_in     = a_second;
        in_valid = 1'b1;
        repeat (20) @(negedge clk);
        in_valid = 1'b0;
        wait_for_result(seen);
        if (seen) compare_factor(l_first);
        repeat (2) @(negedge clk);
        assert (in_ready) else begin
            $display("mismatch at %0t: in_ready still low two cycles after out_valid",
                     $time);
            errors++;
        end
        end_test("input while busy", errs_before);

        errs_before = errors;
        pick_random_factor();
        a_first = product_words();
        l_first = factor_words();
        pick_random_factor();
        a_second = product_words();
        l_second = factor_words();
        send_matrix(a_first);
        wait_for_result(seen);
        if (seen) compare_factor(l_first);
        @(negedge clk);
        assert (in_ready) else begin
            $display("mismatch at %0t: in_ready low in the cycle after out_valid", $time);
            errors++;
        end
        a_in     = a_second;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        assert (!in_ready) else begin
            $display("mismatch at %0t: second matrix not accepted", $time);
            errors++;
        end
        wait_for_result(seen);
        if (seen) compare_factor(l_second);
        end_test("back-to-back matrices", errs_before);

        repeat (4) @(negedge clk);
        $display("tests run %0d, failed %0d, value errors %0d, property failures %0d",
                 tests_run, tests_failed, errors, dut0.props0.fail_count);
        if (errors == 0 && tests_failed == 0 && dut0.props0.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
